/* pipe_defines.svh */
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Width of data words and byte addresses
`define PIPE_XLEN 32

// Word-index bits of the data RAM (1024 words)
`define PIPE_DMEM_AW 10

`endif

/* pipe_pkg.sv */
`default_nettype none

`include "pipe_defines.svh"

package pipe_pkg;

    typedef logic [`PIPE_XLEN-1:0]    word_t;
    typedef logic [4:0]               reg_idx_t;
    typedef logic [3:0]               byte_en_t;
    typedef logic [`PIPE_DMEM_AW-1:0] dmem_idx_t;

    // One-hot operation codes, all zero means no operation
    typedef logic [4:0] load_op_t;    // lbu, lhu, lw, lb, lh
    typedef logic [2:0] store_op_t;   // sb, sh, sw
    typedef logic [8:0] branch_op_t;  // Conditions in bits 0 to 5, jumps in 6 to 8

    typedef struct packed {
        logic carry;
        logic sign;
        logic overflow;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        word_t      pc;
        word_t      alu_result;   // Also the byte address of a memory access
        word_t      store_data;
        reg_idx_t   dest;
        logic       reg_we;
        logic       mem_to_reg;
        load_op_t   load_op;
        store_op_t  store_op;
        alu_flags_t flags;
        branch_op_t branch_op;
        word_t      br_target;
    } ex_to_mem_t;

    typedef struct packed {
        logic      en;
        byte_en_t  we;
        dmem_idx_t idx;
        word_t     wdata;
    } dmem_req_t;

    typedef struct packed {
        word_t    pc;
        logic     reg_we;
        reg_idx_t dest;
        word_t    final_result;
    } mem_to_wb_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        word_t pc;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        logic     valid;
        logic     reg_we;
        reg_idx_t dest;
        word_t    value;
    } fw_bus_t;

    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } rf_write_t;

endpackage

`default_nettype wire

/* mem_request.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module mem_request
    import pipe_pkg::*;
(
    input  logic       ex_valid,
    input  logic       ex_allowin,
    input  ex_to_mem_t ex_bus,
    output dmem_req_t  dmem_req
);

    logic     xfer;
    logic     is_load;
    logic     is_store;
    logic [1:0] lane;
    byte_en_t strobe;
    word_t    wdata;

    assign xfer     = ex_valid && ex_allowin;
    assign is_load  = |ex_bus.load_op;
    assign is_store = |ex_bus.store_op;
    assign lane     = ex_bus.alu_result[1:0];

    // Narrow stores put copies of the data on every lane, the strobes pick one
    always_comb begin
        strobe = '0;
        wdata  = ex_bus.store_data;
        if (ex_bus.store_op[0]) begin
            strobe = byte_en_t'(4'b0001 << lane);
            wdata  = {4{ex_bus.store_data[7:0]}};
        end else if (ex_bus.store_op[1]) begin
            strobe = lane[1] ? 4'b1100 : 4'b0011;  // Bit 0 of the address is ignored
            wdata  = {2{ex_bus.store_data[15:0]}};
        end else if (ex_bus.store_op[2]) begin
            strobe = 4'b1111;
        end
    end

    assign dmem_req.en    = xfer && (is_load || is_store);
    assign dmem_req.we    = xfer ? strobe : '0;
    assign dmem_req.idx   = ex_bus.alu_result[`PIPE_DMEM_AW+1:2];  // Word index
    assign dmem_req.wdata = wdata;

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module data_ram
    import pipe_pkg::*;
#(
    parameter int DEPTH_LOG2 = `PIPE_DMEM_AW
) (
    input  logic      clk,
    input  dmem_req_t dmem_req,
    output word_t     rdata
);

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam int LANES = $bits(byte_en_t);

    word_t                 mem [DEPTH];
    logic [DEPTH_LOG2-1:0] addr;

    assign addr = DEPTH_LOG2'(dmem_req.idx);

    always_ff @(posedge clk) begin
        if (dmem_req.en) begin
            for (int i = 0; i < LANES; i++) begin
                if (dmem_req.we[i]) begin
                    mem[addr][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
                end
            end
            // A store leaves the read register alone, so a held load keeps its word
            if (dmem_req.we == '0) begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ex_valid,
    input  ex_to_mem_t ex_bus,
    input  logic       ws_allowin,
    input  word_t      dmem_rdata,
    output logic       ex_allowin,
    output logic       ms_valid,
    output mem_to_wb_t ms_bus,
    output br_bus_t    br_bus,
    output fw_bus_t    fw_bus
);

    ex_to_mem_t ms_r;
    logic [1:0] lane;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;
    logic       byte_sign;
    logic       half_sign;
    word_t      load_result;
    word_t      final_result;
    logic       br_taken;

    // Loads finish in one cycle, so the stage only waits on write-back
    assign ex_allowin = !ms_valid || ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ex_allowin) begin
            ms_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_allowin) begin
            ms_r <= ex_bus;
        end
    end

    assign lane      = ms_r.alu_result[1:0];
    assign ld_byte   = dmem_rdata[8*lane +: 8];
    assign ld_half   = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];
    assign byte_sign = ms_r.load_op[3] && ld_byte[7];
    assign half_sign = ms_r.load_op[4] && ld_half[15];

    // The loaded part stays in its own lane and the bits above it are extended
    always_comb begin
        load_result = '0;
        if (ms_r.load_op[0] || ms_r.load_op[3]) begin
            case (lane)
                2'd0:    load_result = {{24{byte_sign}}, ld_byte};
                2'd1:    load_result = {{16{byte_sign}}, ld_byte, 8'h00};
                2'd2:    load_result = {{8{byte_sign}}, ld_byte, 16'h0000};
                default: load_result = {ld_byte, 24'h000000};
            endcase
        end else if (ms_r.load_op[1] || ms_r.load_op[4]) begin
            if (lane[1]) begin
                load_result = {ld_half, 16'h0000};
            end else begin
                load_result = {{16{half_sign}}, ld_half};
            end
        end else if (ms_r.load_op[2]) begin
            load_result = dmem_rdata;
        end
    end

    assign final_result = ms_r.mem_to_reg ? load_result : ms_r.alu_result;

    assign br_taken = (ms_r.branch_op[0] && ms_r.flags.zero)
                   || (ms_r.branch_op[1] && !ms_r.flags.zero)
                   || (ms_r.branch_op[2] && (ms_r.flags.sign != ms_r.flags.overflow))
                   || (ms_r.branch_op[3] && (ms_r.flags.zero
                                             || (ms_r.flags.sign == ms_r.flags.overflow)))
                   || (ms_r.branch_op[4] && ms_r.flags.carry)
                   || (ms_r.branch_op[5] && (ms_r.flags.zero || !ms_r.flags.carry))
                   || (|ms_r.branch_op[8:6]);  // Jumps

    assign ms_bus.pc           = ms_r.pc;
    assign ms_bus.reg_we       = ms_r.reg_we;
    assign ms_bus.dest         = ms_r.dest;
    assign ms_bus.final_result = final_result;

    assign br_bus.valid  = ms_valid;
    assign br_bus.taken  = br_taken;
    assign br_bus.pc     = ms_r.pc;
    assign br_bus.target = ms_r.br_target;

    // Execute compares dest against its sources and bypasses the ALU value
    assign fw_bus.valid  = ms_valid;
    assign fw_bus.reg_we = ms_r.reg_we;
    assign fw_bus.dest   = ms_r.dest;
    assign fw_bus.value  = ms_r.alu_result;

endmodule

`default_nettype wire

/* wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ms_valid,
    input  mem_to_wb_t ms_bus,
    input  logic       retire_ready,
    output logic       ws_allowin,
    output logic       retire_valid,
    output word_t      retire_pc,
    output rf_write_t  rf_write
);

    logic       ws_valid;
    mem_to_wb_t ws_r;
    logic       retire_fire;

    // A result leaving this cycle frees the slot for the next one
    assign ws_allowin  = !ws_valid || retire_ready;
    assign retire_fire = ws_valid && retire_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && ws_allowin) begin
            ws_r <= ms_bus;
        end
    end

    assign retire_valid = ws_valid;
    assign retire_pc    = ws_r.pc;

    // Register 0 is hardwired to zero in the register file
    assign rf_write.we   = retire_fire && ws_r.reg_we && (ws_r.dest != '0);
    assign rf_write.addr = ws_r.dest;
    assign rf_write.data = ws_r.final_result;

endmodule

`default_nettype wire

/* mem_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module mem_wb_top
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ex_valid,
    input  ex_to_mem_t ex_bus,
    input  logic       retire_ready,
    output logic       ex_allowin,
    output br_bus_t    br_bus,
    output fw_bus_t    fw_bus,
    output logic       retire_valid,
    output word_t      retire_pc,
    output rf_write_t  rf_write
);

    dmem_req_t  dmem_req;
    word_t      dmem_rdata;
    logic       ms_valid;
    mem_to_wb_t ms_bus;
    logic       ws_allowin;

    mem_request u_mem_request (
        .ex_valid   (ex_valid),
        .ex_allowin (ex_allowin),
        .ex_bus     (ex_bus),
        .dmem_req   (dmem_req)
    );

    data_ram #(
        .DEPTH_LOG2 (`PIPE_DMEM_AW)
    ) u_data_ram (
        .clk      (clk),
        .dmem_req (dmem_req),
        .rdata    (dmem_rdata)
    );

    mem_stage u_mem_stage (
        .clk        (clk),
        .reset      (reset),
        .ex_valid   (ex_valid),
        .ex_bus     (ex_bus),
        .ws_allowin (ws_allowin),
        .dmem_rdata (dmem_rdata),
        .ex_allowin (ex_allowin),
        .ms_valid   (ms_valid),
        .ms_bus     (ms_bus),
        .br_bus     (br_bus),
        .fw_bus     (fw_bus)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .reset        (reset),
        .ms_valid     (ms_valid),
        .ms_bus       (ms_bus),
        .retire_ready (retire_ready),
        .ws_allowin   (ws_allowin),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .rf_write     (rf_write)
    );

endmodule

`default_nettype wire

/* mem_wb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_assertions
    import pipe_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      retire_valid,
    input logic      retire_ready,
    input word_t     retire_pc,
    input rf_write_t rf_write,
    input br_bus_t   br_bus,
    input fw_bus_t   fw_bus
);

    // An offered result stays put until the outside takes it
    retire_hold: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc))
        else $error("Retirement offer changed while retire_ready was low");

    rf_we_fire: assert property (@(posedge clk) disable iff (reset)
        rf_write.we |-> retire_valid && retire_ready)
        else $error("Register write issued outside an accepted retirement");

    rf_no_r0: assert property (@(posedge clk) disable iff (reset)
        rf_write.we |-> rf_write.addr != '0)
        else $error("Register write targets register 0");

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !retire_valid && !br_bus.valid && !fw_bus.valid && !rf_write.we)
        else $error("A valid output was high in the first cycle after reset");

endmodule

bind mem_wb_top mem_wb_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_pc    (retire_pc),
    .rf_write     (rf_write),
    .br_bus       (br_bus),
    .fw_bus       (fw_bus)
);

`default_nettype wire

/* mem_wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_tb
    import pipe_pkg::*;
();

    localparam word_t BASE        = 32'h0000_0200;  // Start of the data window in the RAM
    localparam int    WINDOW      = 64;
    localparam int    NUM_RETIRE  = 2000;
    localparam int    RUN_LIMIT   = 40000;
    localparam int    STALL_LIMIT = 500;

    typedef struct packed {
        word_t    pc;
        logic     reg_we;
        reg_idx_t dest;
        word_t    result;
        logic     taken;
        word_t    target;
        word_t    alu;
    } expect_t;

    logic       clk;
    logic       reset;
    logic       ex_valid;
    ex_to_mem_t ex_bus;
    logic       retire_ready;
    logic       ex_allowin;
    br_bus_t    br_bus;
    fw_bus_t    fw_bus;
    logic       retire_valid;
    word_t      retire_pc;
    rf_write_t  rf_write;

    logic [7:0] mem_b [WINDOW];  // Byte image of the data window
    bit         wr_b [WINDOW];
    expect_t    exp_q [$];
    word_t      next_pc;
    int         retired;
    int         cycles;
    int         last_retire_cycle;
    bit         accepted_now;
    ex_to_mem_t cur;
    logic       ms_full;  // Predicted occupancy of the memory stage
    logic       ws_full;  // Predicted occupancy of the write-back stage

    mem_wb_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_bus       (ex_bus),
        .retire_ready (retire_ready),
        .ex_allowin   (ex_allowin),
        .br_bus       (br_bus),
        .fw_bus       (fw_bus),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .rf_write     (rf_write)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            abort_run("A DUT output did not match the reference model");
        end
    endtask

    function automatic word_t model_word(input int off);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = mem_b[(off & ~3) + i];
        end
        return w;
    endfunction

    function automatic bit word_written(input int off);
        return wr_b[off & ~3] && wr_b[(off & ~3) + 1] && wr_b[(off & ~3) + 2]
            && wr_b[(off & ~3) + 3];
    endfunction

    // Loaded field sits in its own lane with zeros below it and sign or zeros above it
    function automatic word_t load_value(input load_op_t op, input int off);
        word_t w;
        word_t r;
        logic  s;
        int    lo;
        int    width;
        w = model_word(off);
        r = '0;
        if (op[2]) begin
            return w;
        end
        if (op[0] || op[3]) begin
            lo    = 8 * (off % 4);
            width = 8;
        end else begin
            lo    = 16 * ((off / 2) % 2);
            width = 16;
        end
        s = (op[3] || op[4]) && w[lo + width - 1];
        for (int i = 0; i < 32; i++) begin
            if (i >= lo + width) begin
                r[i] = s;
            end else if (i >= lo) begin
                r[i] = w[i];
            end
        end
        return r;
    endfunction

    function automatic logic branch_taken(input branch_op_t op, input alu_flags_t f);
        logic t;
        t = |op[8:6];  // Jumps
        if (op[0] && f.zero) t = 1'b1;
        if (op[1] && !f.zero) t = 1'b1;
        if (op[2] && (f.sign != f.overflow)) t = 1'b1;
        if (op[3] && (f.zero || (f.sign == f.overflow))) t = 1'b1;
        if (op[4] && f.carry) t = 1'b1;
        if (op[5] && (f.zero || !f.carry)) t = 1'b1;
        return t;
    endfunction

    task automatic apply_store(input store_op_t op, input int off, input word_t d);
        int first;
        int count;
        if (op[0]) begin
            first = off;
            count = 1;
        end else if (op[1]) begin
            first = (off & ~3) + 2 * ((off / 2) % 2);
            count = 2;
        end else begin
            first = off & ~3;
            count = 4;
        end
        for (int i = 0; i < count; i++) begin
            mem_b[first + i] = d[8*i +: 8];
            wr_b[first + i]  = 1'b1;
        end
    endtask

    task automatic make_instr(output ex_to_mem_t ins);
        int kind;
        int off;
        ins            = '0;
        ins.pc         = next_pc;
        next_pc        = next_pc + 4;
        ins.dest       = reg_idx_t'($urandom);
        ins.flags      = 4'($urandom);
        ins.alu_result = $urandom;
        ins.store_data = $urandom;
        ins.br_target  = $urandom;
        kind = $urandom_range(3, 0);
        off  = $urandom_range(WINDOW - 1, 0);
        if (kind == 1 && !word_written(off)) begin
            kind = 2;  // RAM has no reset, so write before reading
        end
        case (kind)
            0: ins.reg_we = ($urandom_range(7, 0) != 0);
            1: begin
                ins.alu_result = BASE + off;
                ins.load_op    = load_op_t'(1 << $urandom_range(4, 0));
                ins.mem_to_reg = 1'b1;
                ins.reg_we     = 1'b1;
            end
            2: begin
                ins.alu_result = BASE + off;
                ins.store_op   = store_op_t'(1 << $urandom_range(2, 0));
            end
            default: ins.branch_op = branch_op_t'(1 << $urandom_range(8, 0));
        endcase
    endtask

    always @(posedge clk) begin : monitor
        expect_t e;
        logic    fire;
        logic    ws_allow;
        logic    ms_allow;
        int      off;
        if (reset) begin
            ms_full = 1'b0;
            ws_full = 1'b0;
        end else begin
            fire     = ws_full && retire_ready;
            ws_allow = !ws_full || retire_ready;
            ms_allow = !ms_full || ws_allow;
            check("retire_valid", retire_valid, ws_full);
            check("ex_allowin", ex_allowin, ms_allow);
            check("br_bus.valid", br_bus.valid, ms_full);
            check("fw_bus.valid", fw_bus.valid, ms_full);
            if (!fire) begin
                check("rf_write.we", rf_write.we, 1'b0);
            end
            if (ms_full) begin
                e = exp_q[$];  // Memory stage holds the newest accepted instruction
                check("br_bus.pc", br_bus.pc, e.pc);
                check("br_bus.taken", br_bus.taken, e.taken);
                check("br_bus.target", br_bus.target, e.target);
                check("fw_bus.reg_we", fw_bus.reg_we, e.reg_we);
                check("fw_bus.dest", fw_bus.dest, e.dest);
                check("fw_bus.value", fw_bus.value, e.alu);
            end
            if (fire) begin
                e = exp_q.pop_front();
                check("retire_pc", retire_pc, e.pc);
                check("rf_write.we", rf_write.we, e.reg_we && (e.dest != '0));
                if (e.reg_we && (e.dest != '0)) begin
                    check("rf_write.addr", rf_write.addr, e.dest);
                    check("rf_write.data", rf_write.data, e.result);
                end
                retired++;
                last_retire_cycle = cycles;
            end
            accepted_now = ex_valid && ms_allow;
            if (accepted_now) begin
                off      = int'(ex_bus.alu_result - BASE);
                e.pc     = ex_bus.pc;
                e.reg_we = ex_bus.reg_we;
                e.dest   = ex_bus.dest;
                e.alu    = ex_bus.alu_result;
                e.result = ex_bus.mem_to_reg ? load_value(ex_bus.load_op, off)
                                             : ex_bus.alu_result;
                e.taken  = branch_taken(ex_bus.branch_op, ex_bus.flags);
                e.target = ex_bus.br_target;
                if (|ex_bus.store_op) begin
                    apply_store(ex_bus.store_op, off, ex_bus.store_data);
                end
                exp_q.push_back(e);
            end
            // Write-back takes the old memory stage content before the memory stage refills
            if (ws_allow) begin
                ws_full = ms_full;
            end
            if (ms_allow) begin
                ms_full = ex_valid;
            end
        end
    end

    initial begin
        void'($urandom(32'h64ba));
        reset             = 1'b1;
        ex_valid          = 1'b0;
        ex_bus            = '0;
        retire_ready      = 1'b0;
        next_pc           = 32'h0000_1000;
        retired           = 0;
        cycles            = 0;
        last_retire_cycle = 0;
        accepted_now      = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (4) begin
            @(posedge clk);  // Every valid output must stay low in these idle cycles
            #1;
        end
        while (retired < NUM_RETIRE) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > RUN_LIMIT) begin
                abort_run("Timed out before all instructions retired");
            end
            if (cycles - last_retire_cycle > STALL_LIMIT) begin
                abort_run("Timed out waiting for the next retirement");
            end
            if (accepted_now) begin
                ex_valid = 1'b0;
            end
            if (!ex_valid && $urandom_range(9, 0) < 7) begin
                make_instr(cur);
                ex_bus   = cur;
                ex_valid = 1'b1;
            end
            retire_ready = ($urandom_range(3, 0) != 0);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
pipe_pkg.sv
mem_request.sv
data_ram.sv
mem_stage.sv
wb_stage.sv
mem_wb_top.sv
mem_wb_assertions.sv
mem_wb_tb.sv

/* Bender.yml */
package:
  name: mem_wb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pipe_pkg.sv
      - mem_request.sv
      - data_ram.sv
      - mem_stage.sv
      - wb_stage.sv
      - mem_wb_top.sv
  - target: test
    files:
      - mem_wb_assertions.sv
      - mem_wb_tb.sv
